// ==== all.f ====
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/alu.sv
verilog/main_memory.sv
verilog/cpu_core.sv
verilog/computer.sv
tb/tb_clock.sv
tb/computer_assert.sv
tb/tb_computer.sv

// ==== run.sh ====
#!/bin/sh
# build and run the computer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_computer -f all.f -o sim_computer

# the printed result line decides pass or fail
result=$(./obj_dir/sim_computer || true)
echo "$result"
if echo "$result" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== tb/computer_assert.sv ====
module computer_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   load_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input cpu_bus_pkg::out_word_t out,
    input logic                   halted
);

    timeunit 1ns;
    timeprecision 1ps;

    // stalled output word holds until taken
    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out))
        else $error("output word changed or dropped while stalled");

    // loads only accepted while idle
    load_idle_only: assert property (@(posedge clk) disable iff (!rst_n)
        load_ready |-> halted)
        else $error("load_ready high while the core runs");

    // no output from an idle core
    no_out_idle: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !out_valid)
        else $error("out_valid high while halted");

endmodule

bind computer computer_assert i_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_ready (load_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out        (out),
    .halted     (halted)
);

// ==== tb/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset low for two rising edges, released just after the edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tb/tb_computer.sv ====
`include "cpu_defs.svh"

module tb_computer;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       load_valid;
    logic       load_ready;
    load_word_t load;
    logic       out_valid;
    logic       out_ready = 1'b1;
    out_word_t  out;
    logic       halted;

    // program image, zero words decode as HALT
    logic [`CPU_DATA_W-1:0] image [0:`CPU_MEM_DEPTH-1];
    out_word_t expected [$];
    out_word_t want;
    int  pos;
    int  errors;
    int  cycles;
    int  run_begin;
    int  cycle_limit;
    bit  running;
    bit  random_ready;
    int  stall_left;

    tb_clock i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    computer i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load       (load),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out        (out),
        .halted     (halted)
    );

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // alu behaviour per opcode table, b is the zero-extended immediate
    function automatic logic [15:0] alu_model(input logic [3:0] op, input logic [15:0] a,
                                              input logic [15:0] b);
        case (op)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return a * b;
            4'h3: return (b == 16'h0) ? 16'hffff : a / b;
            4'h4: return a << 1;
            4'h5: return a >> 1;
            4'h6: return (a << 1) | (a >> 15);
            4'h7: return (a >> 1) | (a << 15);
            4'h8: return a & b;
            4'h9: return a | b;
            4'ha: return a ^ b;
            4'hb: return ~(a | b);
            4'hc: return ~(a & b);
            4'hd: return ~(a ^ b);
            4'he: return (a > b) ? 16'h1 : 16'h0;
            default: return (a == b) ? 16'h1 : 16'h0;
        endcase
    endfunction

    // instruction-set interpreter, fills the expected queue, returns instructions run
    function int run_reference();
        logic [15:0] m [0:`CPU_MEM_DEPTH-1];
        logic [11:0] pc;
        logic [11:0] at;
        logic [15:0] acc;
        logic [15:0] w;
        logic [15:0] imm;
        out_word_t   word;
        int          steps;
        bit          done;
        m = image;
        pc = '0;
        acc = '0;
        steps = 0;
        done = 1'b0;
        expected.delete();
        while (!done && steps < 20000) begin
            w = m[pc];
            at = pc;
            pc = pc + 1'b1;
            imm = {8'h00, w[7:0]};
            steps++;
            case (w[15:12])
                4'h0: done = 1'b1;
                4'h1: acc = m[w[11:0]];
                4'h2: m[w[11:0]] = acc;
                4'h3: acc = acc + m[w[11:0]];
                4'h4: acc = acc - m[w[11:0]];
                4'h5: acc = acc & m[w[11:0]];
                4'h6: acc = acc | m[w[11:0]];
                4'h7: acc = acc ^ m[w[11:0]];
                4'h8: pc = w[11:0];
                4'h9: pc = (acc == 16'h0) ? w[11:0] : pc;
                4'ha: acc = alu_model(w[11:8], acc, imm);
                4'hb: begin
                    word.addr = at;
                    word.data = acc;
                    expected.push_back(word);
                end
                4'hc: acc = imm;
                default: ;
            endcase
        end
        return steps;
    endfunction

    function automatic logic [15:0] mem_instr(input logic [3:0] op, input int addr);
        return {op, 12'(addr)};
    endfunction

    function automatic logic [15:0] imm_instr(input logic [3:0] op, input logic [3:0] aop,
                                              input logic [7:0] imm);
        return {op, aop, imm};
    endfunction

    task automatic emit(input logic [15:0] word);
        image[pos] = word;
        pos++;
    endtask

    task automatic clear_image();
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            image[i] = '0;
        end
        pos = 0;
    endtask

    // load len words from address 0, start, wait for halt
    task automatic run_program(input int len);
        int steps;
        steps = run_reference();
        // stall allowance per output word covers random back-pressure
        cycle_limit = 4 * steps + len + 24 * expected.size() + 40;
        run_begin = cycles;
        running = 1'b1;
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            #1;
            load_valid = 1'b1;
            load.addr = 12'(i);
            load.data = image[i];
            @(negedge clk);
            while (!load_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        load_valid = 1'b0;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check("halted after start", 32'(halted), 32'd0);
        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
        running = 1'b0;
        if (expected.size() != 0) begin
            errors++;
            $display("ERROR: core halted with %0d expected output words not sent", expected.size());
        end
    endtask

    // every op once on a random acc, then corner cases
    task automatic alu_sweep();
        clear_image();
        for (int op = 0; op < 16; op++) begin
            image['h60 + op] = 16'($urandom);
            emit(mem_instr(OP_LDA, 'h60 + op));
            emit(imm_instr(OP_ALUI, 4'(op), 8'($urandom)));
            emit(mem_instr(OP_OUT, 0));
        end
        image['h70] = 16'h8001;
        emit(mem_instr(OP_LDA, 'h60));
        emit(imm_instr(OP_ALUI, ALU_DIV, 8'h00));
        emit(mem_instr(OP_OUT, 0));
        emit(imm_instr(OP_LDI, 4'h0, 8'h5a));
        emit(imm_instr(OP_ALUI, ALU_EQ, 8'h5a));
        emit(mem_instr(OP_OUT, 0));
        // greater-than is false below and at equal
        emit(imm_instr(OP_LDI, 4'h0, 8'h7f));
        emit(imm_instr(OP_ALUI, ALU_GT, 8'h80));
        emit(mem_instr(OP_OUT, 0));
        emit(imm_instr(OP_LDI, 4'h0, 8'h80));
        emit(imm_instr(OP_ALUI, ALU_GT, 8'h80));
        emit(mem_instr(OP_OUT, 0));
        // both ends wrap
        emit(mem_instr(OP_LDA, 'h70));
        emit(imm_instr(OP_ALUI, ALU_ROL, 8'h00));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_LDA, 'h70));
        emit(imm_instr(OP_ALUI, ALU_ROR, 8'h00));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_HALT, 0));
        run_program(128);
    endtask

    task automatic memory_ops();
        clear_image();
        for (int i = 0; i < 8; i++) begin
            image['h40 + i] = 16'($urandom);
        end
        emit(mem_instr(OP_LDA, 'h40));
        emit(mem_instr(OP_OUT, 0));
        // ADD, SUB, AND, OR, XOR in opcode order
        for (int k = 0; k < 5; k++) begin
            emit(mem_instr(4'(OP_ADD + k), 'h41 + k));
            emit(mem_instr(OP_OUT, 0));
        end
        // store then reload
        emit(mem_instr(OP_STA, 'h50));
        emit(imm_instr(OP_LDI, 4'h0, 8'h00));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_LDA, 'h50));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_HALT, 0));
        run_program(128);
    endtask

    // countdown with OUT at address 1, JZ exits to address 5
    task automatic countdown();
        clear_image();
        image['h30] = 16'($urandom_range(8, 3));
        emit(mem_instr(OP_LDA, 'h30));
        emit(mem_instr(OP_OUT, 0));
        emit(imm_instr(OP_ALUI, ALU_SUB, 8'h01));
        emit(mem_instr(OP_JZ, 5));
        emit(mem_instr(OP_JMP, 1));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_HALT, 0));
        run_program(64);
    endtask

    task automatic backpressure();
        clear_image();
        for (int i = 0; i < 24; i++) begin
            emit(imm_instr(OP_LDI, 4'h0, 8'($urandom)));
            emit(imm_instr(OP_ALUI, ALU_MUL, 8'($urandom)));
            emit(mem_instr(OP_OUT, 0));
        end
        // nonzero acc left behind for the restart
        emit(imm_instr(OP_LDI, 4'h0, 8'ha5));
        emit(mem_instr(OP_HALT, 0));
        random_ready = 1'b1;
        run_program(80);
        random_ready = 1'b0;
    endtask

    // JZ only reaches the second OUT when acc restarted at zero
    task automatic reload();
        clear_image();
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_JZ, 3));
        emit(mem_instr(OP_HALT, 0));
        emit(imm_instr(OP_LDI, 4'h0, 8'h3c));
        emit(mem_instr(OP_OUT, 0));
        emit(mem_instr(OP_HALT, 0));
        run_program(8);
    endtask

    // out_ready pattern, long low stretches in random mode
    always @(posedge clk) begin
        #1;
        if (!random_ready) begin
            out_ready = 1'b1;
        end else if (stall_left > 0) begin
            out_ready = 1'b0;
            stall_left--;
        end else begin
            out_ready = 1'b1;
            if ($urandom_range(3, 0) == 0) begin
                stall_left = int'($urandom_range(20, 4));
            end
        end
    end

    // compare each transferred word, mid-cycle when all is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (!halted) begin
                check("load_ready while running", 32'(load_ready), 32'd0);
            end
            if (out_valid && out_ready) begin
                if (expected.size() == 0) begin
                    errors++;
                    $display("ERROR: output word %h sent with none expected", out);
                end else begin
                    want = expected.pop_front();
                    check("out addr", 32'(out.addr), 32'(want.addr));
                    check("out data", 32'(out.data), 32'(want.data));
                end
            end
        end
    end

    // cycle counter and per-run limit
    always @(posedge clk) begin
        cycles++;
        if (running && (cycles - run_begin) > cycle_limit) begin
            $display("ERROR: timeout, program did not halt within %0d cycles", cycle_limit);
            $display("errors: %0d", errors + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h834dc571));
        start = 1'b0;
        load_valid = 1'b0;
        load = '0;
        random_ready = 1'b0;
        running = 1'b0;
        stall_left = 0;
        cycles = 0;
        run_begin = 0;
        cycle_limit = 0;
        errors = 0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check("halted after reset", 32'(halted), 32'd1);
        check("load_ready after reset", 32'(load_ready), 32'd1);
        check("out_valid after reset", 32'(out_valid), 32'd0);
        clear_image();
        run_program(16);
        alu_sweep();
        memory_ops();
        countdown();
        backpressure();
        reload();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`include "cpu_defs.svh"

module alu (
    input  cpu_isa_pkg::alu_op_e    op,
    input  logic [`CPU_DATA_W-1:0]  a,
    input  logic [`CPU_DATA_W-1:0]  b,
    output logic [`CPU_DATA_W-1:0]  result
);

    import cpu_isa_pkg::*;

    // purely combinational, single operand ops ignore b
    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            // low half of the product only
            ALU_MUL: begin
                result = a * b;
            end
            // divide by zero saturates to all ones
            ALU_DIV: begin
                result = (b == '0) ? '1 : a / b;
            end
            ALU_SHL: begin
                result = {a[`CPU_DATA_W-2:0], 1'b0};
            end
            ALU_SHR: begin
                result = {1'b0, a[`CPU_DATA_W-1:1]};
            end
            // msb wraps into bit 0
            ALU_ROL: begin
                result = {a[`CPU_DATA_W-2:0], a[`CPU_DATA_W-1]};
            end
            // bit 0 wraps into msb
            ALU_ROR: begin
                result = {a[0], a[`CPU_DATA_W-1:1]};
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_NOR: begin
                result = ~(a | b);
            end
            ALU_NAND: begin
                result = ~(a & b);
            end
            ALU_XNOR: begin
                result = ~(a ^ b);
            end
            // compares give 1 or 0, unsigned
            ALU_GT: begin
                result = {{(`CPU_DATA_W-1){1'b0}}, (a > b)};
            end
            ALU_EQ: begin
                result = {{(`CPU_DATA_W-1){1'b0}}, (a == b)};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== verilog/computer.sv ====
`include "cpu_defs.svh"

module computer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  cpu_bus_pkg::load_word_t load,
    output logic                    out_valid,
    input  logic                    out_ready,
    output cpu_bus_pkg::out_word_t  out,
    output logic                    halted
);

    import cpu_bus_pkg::*;

    // core to memory, no handshake
    logic                   mem_en;
    mem_req_t               mem_req;
    logic [`CPU_DATA_W-1:0] mem_rdata;

    cpu_core i_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load       (load),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out        (out),
        .halted     (halted),
        .mem_en     (mem_en),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata)
    );

    // program and data share one array
    main_memory i_mem (
        .clk   (clk),
        .en    (mem_en),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

// ==== verilog/cpu_bus_pkg.sv ====
`include "cpu_defs.svh"

package cpu_bus_pkg;

    // core to main memory, one access per enabled cycle
    typedef struct packed {
        // write when set, read otherwise
        logic                   we;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
    } mem_req_t;

    // host program load word
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
    } load_word_t;

    // output stream word
    typedef struct packed {
        // location of the OUT instruction
        logic [`CPU_ADDR_W-1:0] addr;
        // accumulator at OUT time
        logic [`CPU_DATA_W-1:0] data;
    } out_word_t;

endpackage

// ==== verilog/cpu_core.sv ====
`include "cpu_defs.svh"

module cpu_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    load_valid,
    output logic                    load_ready,
    input  cpu_bus_pkg::load_word_t load,
    output logic                    out_valid,
    input  logic                    out_ready,
    output cpu_bus_pkg::out_word_t  out,
    output logic                    halted,
    output logic                    mem_en,
    output cpu_bus_pkg::mem_req_t   mem_req,
    input  logic [`CPU_DATA_W-1:0]  mem_rdata
);

    import cpu_isa_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_WRITEBACK,
        S_OUTPUT
    } state_e;

    state_e state;

    // architectural registers
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] mar;
    instr_t                 ir;
    logic [`CPU_DATA_W-1:0] mbr;
    logic [`CPU_DATA_W-1:0] acc;

    // decode helpers
    instr_t                 fetched;
    opcode_e                opcode;
    logic                   mem_operand;
    logic                   acc_zero;
    logic [`CPU_DATA_W-1:0] imm_ext;

    // alu hookup
    alu_op_e                alu_op;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic [`CPU_DATA_W-1:0] alu_result;

    // word coming back from the FETCH read
    assign fetched = mem_rdata;

    // both views share the opcode nibble
    assign opcode  = ir.mem_form.opcode;
    assign imm_ext = {{(`CPU_DATA_W-8){1'b0}}, ir.imm_form.imm};
    assign acc_zero = (acc == '0);

    // opcodes that read an operand from memory
    assign mem_operand = (opcode == OP_LDA) || (opcode == OP_ADD) || (opcode == OP_SUB)
                      || (opcode == OP_AND) || (opcode == OP_OR) || (opcode == OP_XOR);

    // host side status
    assign halted     = (state == S_IDLE);
    assign load_ready = (state == S_IDLE);

    // valid from EXECUTE so a ready host takes the word in three cycles
    assign out_valid = ((state == S_EXECUTE) && (opcode == OP_OUT)) || (state == S_OUTPUT);
    // pc already points past the OUT instruction
    assign out.addr  = pc - 1'b1;
    assign out.data  = acc;

    // alu operands
    always_comb begin
        alu_op = ir.imm_form.alu_op;
        alu_b  = imm_ext;
        // memory operand ops combine in writeback
        if (state == S_WRITEBACK) begin
            alu_b = mem_rdata;
            case (opcode)
                OP_SUB: begin
                    alu_op = ALU_SUB;
                end
                OP_AND: begin
                    alu_op = ALU_AND;
                end
                OP_OR: begin
                    alu_op = ALU_OR;
                end
                OP_XOR: begin
                    alu_op = ALU_XOR;
                end
                default: begin
                    alu_op = ALU_ADD;
                end
            endcase
        end
    end

    alu i_alu (
        .op     (alu_op),
        .a      (acc),
        .b      (alu_b),
        .result (alu_result)
    );

    // single driver for the memory port
    always_comb begin
        mem_en  = 1'b0;
        mem_req = '0;
        case (state)
            // host load, ready is always high here
            S_IDLE: begin
                if (load_valid) begin
                    mem_en        = 1'b1;
                    mem_req.we    = 1'b1;
                    mem_req.addr  = load.addr;
                    mem_req.wdata = load.data;
                end
            end
            // instruction read
            S_FETCH: begin
                mem_en       = 1'b1;
                mem_req.addr = pc;
            end
            S_EXECUTE: begin
                // operand read, data lands in writeback
                if (mem_operand) begin
                    mem_en       = 1'b1;
                    mem_req.addr = mar;
                end
                // store of the acc snapshot
                if (opcode == OP_STA) begin
                    mem_en        = 1'b1;
                    mem_req.we    = 1'b1;
                    mem_req.addr  = mar;
                    mem_req.wdata = mbr;
                end
            end
            default: begin
                mem_en = 1'b0;
            end
        endcase
    end

    // control state, pc and acc
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // start ignored unless idle
                    if (start) begin
                        pc    <= '0;
                        acc   <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state <= S_DECODE;
                end
                // pc wraps at the top of memory
                S_DECODE: begin
                    pc    <= pc + 1'b1;
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    state <= S_FETCH;
                    case (opcode)
                        OP_HALT: begin
                            state <= S_IDLE;
                        end
                        OP_LDA, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                            state <= S_WRITEBACK;
                        end
                        OP_JMP: begin
                            pc <= mar;
                        end
                        OP_JZ: begin
                            if (acc_zero) begin
                                pc <= mar;
                            end
                        end
                        OP_ALUI: begin
                            acc <= alu_result;
                        end
                        // hold everything until the host takes the word
                        OP_OUT: begin
                            if (!out_ready) begin
                                state <= S_OUTPUT;
                            end
                        end
                        OP_LDI: begin
                            acc <= imm_ext;
                        end
                        default: begin
                            state <= S_FETCH;
                        end
                    endcase
                end
                // operand is on mem_rdata now
                S_WRITEBACK: begin
                    acc   <= (opcode == OP_LDA) ? mem_rdata : alu_result;
                    state <= S_FETCH;
                end
                S_OUTPUT: begin
                    if (out_ready) begin
                        state <= S_FETCH;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // instruction, operand address and store data, latched in decode
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir  <= fetched;
            mar <= fetched.mem_form.addr;
            // acc cannot change before STA executes
            mbr <= acc;
        end
    end

endmodule

// ==== verilog/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and instruction word width
`define CPU_DATA_W 16

// word address width, one word per address
`define CPU_ADDR_W 12

// main memory size in words
`define CPU_MEM_DEPTH 4096

`endif

// ==== verilog/cpu_isa_pkg.sv ====
`include "cpu_defs.svh"

package cpu_isa_pkg;

    // top nibble of every instruction
    typedef enum logic [3:0] {
        OP_HALT  = 4'h0,
        OP_LDA   = 4'h1,
        OP_STA   = 4'h2,
        OP_ADD   = 4'h3,
        OP_SUB   = 4'h4,
        OP_AND   = 4'h5,
        OP_OR    = 4'h6,
        OP_XOR   = 4'h7,
        OP_JMP   = 4'h8,
        OP_JZ    = 4'h9,
        OP_ALUI  = 4'hA,
        OP_OUT   = 4'hB,
        OP_LDI   = 4'hC,
        // spare codes, all behave as no-operation
        OP_NOP_D = 4'hD,
        OP_NOP_E = 4'hE,
        OP_NOP_F = 4'hF
    } opcode_e;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_MUL  = 4'h2,
        ALU_DIV  = 4'h3,
        ALU_SHL  = 4'h4,
        ALU_SHR  = 4'h5,
        ALU_ROL  = 4'h6,
        ALU_ROR  = 4'h7,
        ALU_AND  = 4'h8,
        ALU_OR   = 4'h9,
        ALU_XOR  = 4'hA,
        ALU_NOR  = 4'hB,
        ALU_NAND = 4'hC,
        ALU_XNOR = 4'hD,
        ALU_GT   = 4'hE,
        ALU_EQ   = 4'hF
    } alu_op_e;

    // memory form: opcode plus word address
    typedef struct packed {
        opcode_e                opcode;
        logic [`CPU_ADDR_W-1:0] addr;
    } instr_mem_t;

    // immediate form: opcode, alu function, 8-bit immediate
    typedef struct packed {
        opcode_e    opcode;
        alu_op_e    alu_op;
        logic [7:0] imm;
    } instr_imm_t;

    // one instruction word, two decodings
    typedef union packed {
        instr_mem_t mem_form;
        instr_imm_t imm_form;
    } instr_t;

endpackage

// ==== verilog/main_memory.sv ====
`include "cpu_defs.svh"

module main_memory (
    input  logic                   clk,
    input  logic                   en,
    input  cpu_bus_pkg::mem_req_t  req,
    output logic [`CPU_DATA_W-1:0] rdata
);

    // word array, contents undefined until loaded
    logic [`CPU_DATA_W-1:0] mem [0:`CPU_MEM_DEPTH-1];

    // single port, write or read per enabled cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                // read data valid on the next cycle
                rdata <= mem[req.addr];
            end
        end
    end

endmodule
